// File: rtl/scene_consts.svh
`ifndef SCENE_CONSTS_SVH
`define SCENE_CONSTS_SVH

// Property fields
`define SCENE_FIELD_W 16    // Every numeric property
`define SCENE_LTYPE_W 2     // Light kind, taken from the low data bits

// Store depths
`define SCENE_NUM_CAMERAS 2
`define SCENE_NUM_LIGHTS 4

// Record addresses inside one copy of a store
`define SCENE_CAM_AW $clog2(`SCENE_NUM_CAMERAS)
`define SCENE_LIGHT_AW $clog2(`SCENE_NUM_LIGHTS)

// Command word fields
`define SCENE_OP_W 2        // Opcode
`define SCENE_IDX_W 2       // Camera or light index, cameras use the low bit
`define SCENE_PROP_W 4      // Property code

`endif

// File: rtl/scene_types_pkg.sv
`include "scene_consts.svh"

package scene_types_pkg;

    typedef logic [`SCENE_FIELD_W-1:0] field_t;  // One numeric property

    // Kind of light source
    typedef enum logic [`SCENE_LTYPE_W-1:0] {
        light_point       = 2'd0,
        light_directional = 2'd1,
        light_spot        = 2'd2,
        light_ambient     = 2'd3
    } light_type_e;

    // Camera record, 208 bits
    typedef struct packed {
        field_t x_loc;      // Position
        field_t y_loc;
        field_t z_loc;
        field_t x_fwd;      // View direction
        field_t y_fwd;
        field_t z_fwd;
        field_t x_up;       // Up vector
        field_t y_up;
        field_t z_up;
        field_t near_clip;
        field_t far_clip;
        field_t h_fov;      // Horizontal field of view
        field_t v_fov;      // Vertical field of view
    } camera_t;

    // Light record, kind on top, 130 bits
    typedef struct packed {
        light_type_e l_type;
        field_t      x_loc;
        field_t      y_loc;
        field_t      z_loc;
        field_t      x_fwd;  // Direction, spot and directional only
        field_t      y_fwd;
        field_t      z_fwd;
        field_t      color;
        field_t      intensity;
    } light_t;

endpackage

// File: rtl/scene_cmd_pkg.sv
`include "scene_consts.svh"

package scene_cmd_pkg;

    typedef enum logic [`SCENE_OP_W-1:0] {
        op_set_camera = 2'd0,   // Write one camera property
        op_set_light  = 2'd1,   // Write one light property
        op_frame      = 2'd2,   // Swap copies, frame ready
        op_render     = 2'd3    // Render started, clear frame ready
    } scene_op_e;

    // Camera property codes, 13 to 15 unused
    typedef enum logic [`SCENE_PROP_W-1:0] {
        cp_x_loc = 4'd0, cp_y_loc = 4'd1, cp_z_loc = 4'd2,
        cp_x_fwd = 4'd3, cp_y_fwd = 4'd4, cp_z_fwd = 4'd5,
        cp_x_up  = 4'd6, cp_y_up  = 4'd7, cp_z_up  = 4'd8,
        cp_near_clip = 4'd9, cp_far_clip = 4'd10,
        cp_h_fov = 4'd11, cp_v_fov = 4'd12
    } camera_prop_e;

    // Light property codes, 9 to 15 unused
    typedef enum logic [`SCENE_PROP_W-1:0] {
        lp_type  = 4'd0,
        lp_x_loc = 4'd1, lp_y_loc = 4'd2, lp_z_loc = 4'd3,
        lp_x_fwd = 4'd4, lp_y_fwd = 4'd5, lp_z_fwd = 4'd6,
        lp_color = 4'd7, lp_intensity = 4'd8
    } light_prop_e;

    // Host command word, 24 bits
    typedef struct packed {
        scene_op_e                 op;
        logic [`SCENE_IDX_W-1:0]   index;  // Camera or light number
        logic [`SCENE_PROP_W-1:0]  prop;   // Camera or light property code
        logic [`SCENE_FIELD_W-1:0] data;
    } scene_cmd_t;

endpackage

// File: rtl/scene_cmd_intake.sv
`timescale 1ns/1ps

module scene_cmd_intake import scene_cmd_pkg::*; (
    input  logic       clk_100mhz,
    input  logic       rst,
    input  logic       cmd_req,     // Host request, four-phase
    input  scene_cmd_t cmd,         // Stable while cmd_req is high
    input  logic       upd_ready,   // Updater can take a command
    output logic       cmd_ack,
    output logic       cmd_valid,   // One-cycle pulse to the updater
    output scene_cmd_t cmd_word
);

    typedef enum logic {
        st_idle,    // Waiting for a request
        st_acked    // Command taken, waiting for the host to drop cmd_req
    } state_e;

    state_e state;

    assign cmd_ack = (state == st_acked);  // Ack follows the state directly

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            state     <= st_idle;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;  // Pulse by default low
            case (state)
                st_idle: begin
                    // Held back while the updater is still busy
                    if (cmd_req && upd_ready) begin
                        cmd_valid <= 1'b1;
                        state     <= st_acked;
                    end
                end
                st_acked: begin
                    if (!cmd_req) state <= st_idle;  // Handshake done, ack drops next cycle
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Command payload, captured together with the pulse
    always_ff @(posedge clk_100mhz) begin
        if (state == st_idle && cmd_req && upd_ready) cmd_word <= cmd;
    end

endmodule

// File: rtl/scene_updater.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module scene_updater import scene_types_pkg::*, scene_cmd_pkg::*; (
    input  logic                        clk_100mhz,
    input  logic                        rst,
    input  logic                        cmd_valid,
    input  scene_cmd_t                  cmd_word,
    output logic                        upd_ready,
    output logic                        wr_sel,       // Copy that takes updates
    output logic                        frame_ready,
    output logic [`SCENE_CAM_AW-1:0]    cam_addr,
    output logic                        cam_we,
    output camera_t                     cam_wr_data,
    input  camera_t                     cam_rd_data,
    output logic [`SCENE_LIGHT_AW-1:0]  light_addr,
    output logic                        light_we,
    output light_t                      light_wr_data,
    input  light_t                      light_rd_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,    // Address on the bank, data back next cycle
        st_merge,   // Old record in, replace one field
        st_write    // Merged record written to the write copy
    } state_e;

    state_e     state;
    scene_cmd_t cur;            // Command in flight
    camera_t    cam_merged;
    light_t     light_merged;

    assign upd_ready = (state == st_idle);

    // Same index for read and write of the record
    assign cam_addr   = cur.index[`SCENE_CAM_AW-1:0];
    assign light_addr = cur.index[`SCENE_LIGHT_AW-1:0];

    assign cam_we   = (state == st_write) && (cur.op == op_set_camera);
    assign light_we = (state == st_write) && (cur.op == op_set_light);

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            state       <= st_idle;
            wr_sel      <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        case (cmd_word.op)
                            op_set_camera, op_set_light: state <= st_read;
                            op_frame: begin
                                wr_sel      <= ~wr_sel;  // Written copy becomes visible
                                frame_ready <= 1'b1;
                            end
                            op_render: frame_ready <= 1'b0;
                            default: ;
                        endcase
                    end
                end
                st_read:  state <= st_merge;
                st_merge: state <= st_write;
                st_write: state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // Command held through read, merge and write
    always_ff @(posedge clk_100mhz) begin
        if (state == st_idle && cmd_valid) cur <= cmd_word;
    end

    // Replace the single camera field named by the property code
    always_comb begin
        cam_merged = cam_rd_data;
        case (cur.prop)
            cp_x_loc:     cam_merged.x_loc     = cur.data;
            cp_y_loc:     cam_merged.y_loc     = cur.data;
            cp_z_loc:     cam_merged.z_loc     = cur.data;
            cp_x_fwd:     cam_merged.x_fwd     = cur.data;
            cp_y_fwd:     cam_merged.y_fwd     = cur.data;
            cp_z_fwd:     cam_merged.z_fwd     = cur.data;
            cp_x_up:      cam_merged.x_up      = cur.data;
            cp_y_up:      cam_merged.y_up      = cur.data;
            cp_z_up:      cam_merged.z_up      = cur.data;
            cp_near_clip: cam_merged.near_clip = cur.data;
            cp_far_clip:  cam_merged.far_clip  = cur.data;
            cp_h_fov:     cam_merged.h_fov     = cur.data;
            cp_v_fov:     cam_merged.v_fov     = cur.data;
            default: ;  // Unknown code, record kept as read
        endcase
    end

    // Same for lights, type comes from the low data bits
    always_comb begin
        light_merged = light_rd_data;
        case (cur.prop)
            lp_type:      light_merged.l_type = light_type_e'(cur.data[`SCENE_LTYPE_W-1:0]);
            lp_x_loc:     light_merged.x_loc     = cur.data;
            lp_y_loc:     light_merged.y_loc     = cur.data;
            lp_z_loc:     light_merged.z_loc     = cur.data;
            lp_x_fwd:     light_merged.x_fwd     = cur.data;
            lp_y_fwd:     light_merged.y_fwd     = cur.data;
            lp_z_fwd:     light_merged.z_fwd     = cur.data;
            lp_color:     light_merged.color     = cur.data;
            lp_intensity: light_merged.intensity = cur.data;
            default: ;
        endcase
    end

    // Merged records registered for the write stage
    always_ff @(posedge clk_100mhz) begin
        if (state == st_merge) begin
            cam_wr_data   <= cam_merged;
            light_wr_data <= light_merged;
        end
    end

endmodule

// File: rtl/scene_bank.sv
`timescale 1ns/1ps

module scene_bank #(
    parameter type payload_t = logic,   // Record stored per entry
    parameter int  DEPTH     = 2        // Entries per copy
) (
    input  logic                     clk_100mhz,
    input  logic                     wr_sel,       // Copy on the update port
    input  logic [$clog2(DEPTH)-1:0] upd_addr,
    input  logic                     upd_we,
    input  payload_t                 upd_wr_data,
    output payload_t                 upd_rd_data,  // One cycle after upd_addr
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data       // Render side, other copy
);

    // Both copies, cleared at start
    payload_t store [2][DEPTH] = '{default: '0};

    logic rd_sel;

    assign rd_sel = ~wr_sel;  // Render always sees the copy not being written

    // Update port, read-first on the write copy
    always_ff @(posedge clk_100mhz) begin
        if (upd_we) store[wr_sel][upd_addr] <= upd_wr_data;
        upd_rd_data <= store[wr_sel][upd_addr];
    end

    // Render port, registered read
    always_ff @(posedge clk_100mhz) begin
        rd_data <= store[rd_sel][rd_addr];
    end

endmodule

// File: rtl/render_fetch.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module render_fetch import scene_types_pkg::*; (
    input  logic                        clk_100mhz,
    input  logic                        rst,
    input  logic                        fetch_req,        // Four-phase request
    input  logic [`SCENE_CAM_AW-1:0]    fetch_cam_idx,    // Stable with fetch_req
    input  logic [`SCENE_LIGHT_AW-1:0]  fetch_light_idx,
    output logic [`SCENE_CAM_AW-1:0]    cam_rd_addr,
    output logic [`SCENE_LIGHT_AW-1:0]  light_rd_addr,
    input  camera_t                     cam_rd_data,
    input  light_t                      light_rd_data,
    output logic                        fetch_ack,
    output camera_t                     camera_out,       // Valid while fetch_ack high
    output light_t                      light_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,    // Bank data for the requested records arriving
        st_ack      // Records held, waiting for fetch_req low
    } state_e;

    state_e state;

    // Addresses straight from the request so the bank reads in the request cycle
    assign cam_rd_addr   = fetch_cam_idx;
    assign light_rd_addr = fetch_light_idx;

    assign fetch_ack = (state == st_ack);

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (fetch_req) state <= st_read;
                st_read:  state <= st_ack;
                st_ack:   if (!fetch_req) state <= st_idle;  // Ack drops next cycle
                default:  state <= st_idle;
            endcase
        end
    end

    // Latch both records once the read cycle is done
    always_ff @(posedge clk_100mhz) begin
        if (state == st_read) begin
            camera_out <= cam_rd_data;
            light_out  <= light_rd_data;
        end
    end

endmodule

// File: rtl/scene_memory_top.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module scene_memory_top import scene_types_pkg::*, scene_cmd_pkg::*; (
    input  logic                        clk_100mhz,
    input  logic                        rst,
    input  logic                        cmd_req,          // Host link
    input  scene_cmd_t                  cmd,
    output logic                        cmd_ack,
    input  logic                        fetch_req,        // Render link
    input  logic [`SCENE_CAM_AW-1:0]    fetch_cam_idx,
    input  logic [`SCENE_LIGHT_AW-1:0]  fetch_light_idx,
    output logic                        fetch_ack,
    output camera_t                     camera_out,
    output light_t                      light_out,
    output logic                        frame_ready
);

    logic                       cmd_valid;
    scene_cmd_t                 cmd_word;
    logic                       upd_ready;
    logic                       wr_sel;
    logic [`SCENE_CAM_AW-1:0]   cam_addr, cam_rd_addr;
    logic [`SCENE_LIGHT_AW-1:0] light_addr, light_rd_addr;
    logic                       cam_we, light_we;
    camera_t                    cam_wr_data, cam_rd_data, cam_fetch_data;
    light_t                     light_wr_data, light_rd_data, light_fetch_data;

    scene_cmd_intake intake_i (
        .clk_100mhz, .rst,
        .cmd_req, .cmd, .upd_ready,
        .cmd_ack, .cmd_valid, .cmd_word
    );

    scene_updater updater_i (
        .clk_100mhz, .rst,
        .cmd_valid, .cmd_word, .upd_ready, .wr_sel, .frame_ready,
        .cam_addr, .cam_we, .cam_wr_data, .cam_rd_data,
        .light_addr, .light_we, .light_wr_data, .light_rd_data
    );

    scene_bank #(.payload_t(camera_t), .DEPTH(`SCENE_NUM_CAMERAS)) camera_bank (
        .clk_100mhz, .wr_sel,
        .upd_addr(cam_addr), .upd_we(cam_we),
        .upd_wr_data(cam_wr_data), .upd_rd_data(cam_rd_data),
        .rd_addr(cam_rd_addr), .rd_data(cam_fetch_data)
    );

    scene_bank #(.payload_t(light_t), .DEPTH(`SCENE_NUM_LIGHTS)) light_bank (
        .clk_100mhz, .wr_sel,
        .upd_addr(light_addr), .upd_we(light_we),
        .upd_wr_data(light_wr_data), .upd_rd_data(light_rd_data),
        .rd_addr(light_rd_addr), .rd_data(light_fetch_data)
    );

    render_fetch fetch_i (
        .clk_100mhz, .rst,
        .fetch_req, .fetch_cam_idx, .fetch_light_idx,
        .cam_rd_addr, .light_rd_addr,
        .cam_rd_data(cam_fetch_data), .light_rd_data(light_fetch_data),
        .fetch_ack, .camera_out, .light_out
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 10.0,  // 100 MHz
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_100mhz,
    output logic rst
);

    initial clk_100mhz = 1'b0;
    always #(PERIOD_NS / 2.0) clk_100mhz = ~clk_100mhz;

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_100mhz);
        #1 rst = 1'b0;  // Released just after the edge, like the other inputs
    end

endmodule

// File: sim/scene_memory_tb.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module scene_memory_tb import scene_types_pkg::*, scene_cmd_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 40;   // Per handshake edge
    localparam int CAM_FIELDS     = 13;
    localparam int LIGHT_FIELDS   = 8;    // Numeric fields below the light kind

    logic                       clk_100mhz, rst;
    logic                       cmd_req, cmd_ack, fetch_req, fetch_ack, frame_ready;
    scene_cmd_t                 cmd;
    logic [`SCENE_CAM_AW-1:0]   fetch_cam_idx;
    logic [`SCENE_LIGHT_AW-1:0] fetch_light_idx;
    camera_t                    camera_out;
    light_t                     light_out;

    // Model of both copies indexed by copy and record
    camera_t model_cam [2][`SCENE_NUM_CAMERAS];
    light_t  model_light [2][`SCENE_NUM_LIGHTS];
    logic    model_sel;     // Copy taking writes
    logic    model_ready;

    camera_t     exp_cam_q[$];   // Expected fetch results with the oldest at the front
    light_t      exp_light_q[$];
    logic [15:0] lfsr_state;
    int          errors, checks, tests_run;

    tb_clock_gen clock_gen_i (.clk_100mhz, .rst);

    scene_memory_top scene_memory_top_i (
        .clk_100mhz, .rst,
        .cmd_req, .cmd, .cmd_ack,
        .fetch_req, .fetch_cam_idx, .fetch_light_idx,
        .fetch_ack, .camera_out, .light_out,
        .frame_ready
    );

    // Taps of x^16 + x^14 + x^13 + x^11 + 1 with one output bit per step
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[14:0], lfsr_step()};
        return v;
    endfunction

    // Property code k names field k counted from the top of the record
    function automatic camera_t ref_camera(input camera_t old, input logic [3:0] prop,
                                           input logic [`SCENE_FIELD_W-1:0] data);
        logic [$bits(camera_t)-1:0] v;
        int k;
        v = old;
        k = prop;
        if (k < CAM_FIELDS) v[(CAM_FIELDS - 1 - k) * `SCENE_FIELD_W +: `SCENE_FIELD_W] = data;
        return camera_t'(v);
    endfunction

    // Code 0 is the kind on top and codes 1 to 8 are the fields below it
    function automatic light_t ref_light(input light_t old, input logic [3:0] prop,
                                         input logic [`SCENE_FIELD_W-1:0] data);
        logic [$bits(light_t)-1:0] v;
        int k;
        v = old;
        k = prop;
        if (k == 0)
            v[$bits(light_t)-1 -: `SCENE_LTYPE_W] = data[`SCENE_LTYPE_W-1:0];
        else if (k <= LIGHT_FIELDS)
            v[(LIGHT_FIELDS - k) * `SCENE_FIELD_W +: `SCENE_FIELD_W] = data;
        return light_t'(v);
    endfunction

    function automatic void model_apply(input scene_cmd_t c);
        case (c.op)
            op_set_camera: model_cam[model_sel][c.index[0]] =
                ref_camera(model_cam[model_sel][c.index[0]], c.prop, c.data);
            op_set_light: model_light[model_sel][c.index] =
                ref_light(model_light[model_sel][c.index], c.prop, c.data);
            op_frame: begin
                model_sel   = ~model_sel;  // Written copy goes to the render side
                model_ready = 1'b1;
            end
            default: model_ready = 1'b0;   // Render
        endcase
    endfunction

    task automatic abort_run(input string what);
        $display("%s at time %0t", what, $time);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge clk_100mhz);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("Reset was never released");
        end
        @(posedge clk_100mhz);
        #1;
    endtask

    task automatic wait_cmd_ack(input logic level);
        int cycles;
        cycles = 0;
        while (cmd_ack !== level) begin
            @(posedge clk_100mhz);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                abort_run($sformatf("Timeout, cmd_ack never went to %b", level));
        end
    endtask

    task automatic wait_fetch_ack(input logic level);
        int cycles;
        cycles = 0;
        while (fetch_ack !== level) begin
            @(posedge clk_100mhz);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                abort_run($sformatf("Timeout, fetch_ack never went to %b", level));
        end
    endtask

    // Full four-phase host handshake before the model takes the same command
    task automatic send_cmd(input scene_op_e op, input logic [1:0] index,
                            input logic [3:0] prop, input logic [15:0] data);
        cmd.op    = op;
        cmd.index = index;
        cmd.prop  = prop;
        cmd.data  = data;
        cmd_req   = 1'b1;
        wait_cmd_ack(1'b1);
        cmd_req = 1'b0;
        wait_cmd_ack(1'b0);
        model_apply(cmd);
    endtask

    // Render side reads the copy the model is not writing
    task automatic fetch(input int cam_idx, input int light_idx);
        exp_cam_q.push_back(model_cam[~model_sel][cam_idx]);
        exp_light_q.push_back(model_light[~model_sel][light_idx]);
        fetch_cam_idx   = cam_idx[`SCENE_CAM_AW-1:0];
        fetch_light_idx = light_idx[`SCENE_LIGHT_AW-1:0];
        fetch_req       = 1'b1;
        wait_fetch_ack(1'b1);
        fetch_req = 1'b0;
        wait_fetch_ack(1'b0);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) $display("test %0d, %s: passed", tests_run, name);
        else $display("test %0d, %s: %0d errors", tests_run, name, errors - errors_before);
    endtask

    // One check for each rising fetch_ack seen at a falling clock edge
    initial begin : compare_fetch
        camera_t exp_cam;
        light_t  exp_light;
        logic    ack_prev;
        ack_prev = 1'b0;
        forever begin
            @(negedge clk_100mhz);
            if (fetch_ack && !ack_prev) begin
                if (exp_cam_q.size() == 0) begin
                    errors++;
                    $display("Fetch acknowledged with no expected record at time %0t", $time);
                end else begin
                    exp_cam   = exp_cam_q.pop_front();
                    exp_light = exp_light_q.pop_front();
                    checks += 2;
                    assert (camera_out === exp_cam) else begin
                        errors++;
                        $display("error %0t: camera %h, expected %h", $time, camera_out, exp_cam);
                    end
                    assert (light_out === exp_light) else begin
                        errors++;
                        $display("error %0t: light %h, expected %h", $time, light_out, exp_light);
                    end
                end
            end
            ack_prev = fetch_ack;
        end
    end

    initial begin : stimulus
        int         err0;
        logic [1:0] r_op, r_idx;
        logic [3:0] r_prop;
        cmd_req         = 1'b0;
        cmd             = '0;
        fetch_req       = 1'b0;
        fetch_cam_idx   = '0;
        fetch_light_idx = '0;
        lfsr_state      = 16'd39;
        model_cam       = '{default: '0};  // Stores start cleared
        model_light     = '{default: '0};
        model_sel       = 1'b0;
        model_ready     = 1'b0;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        wait_reset_release();

        err0 = errors;
        check_bit("cmd_ack", cmd_ack, 1'b0);
        check_bit("fetch_ack", fetch_ack, 1'b0);
        check_bit("frame_ready", frame_ready, 1'b0);
        fetch(0, 0);
        fetch(1, 3);
        finish_test("reset state", err0);

        err0 = errors;
        for (int c = 0; c < `SCENE_NUM_CAMERAS; c++)
            for (int p = 0; p < CAM_FIELDS; p++)
                send_cmd(op_set_camera, 2'(c), 4'(p), random_bits(16));
        send_cmd(op_frame, 2'd0, 4'd0, 16'd0);
        check_bit("frame_ready", frame_ready, model_ready);
        fetch(0, 0);
        fetch(1, 1);
        finish_test("camera writes", err0);

        err0 = errors;
        for (int l = 0; l < `SCENE_NUM_LIGHTS; l++)
            for (int p = 0; p < 16; p++) send_cmd(op_set_light, 2'(l), 4'(p), random_bits(16));
        for (int p = CAM_FIELDS; p < 16; p++)  // Unused camera codes
            send_cmd(op_set_camera, 2'(p), 4'(p), random_bits(16));
        send_cmd(op_frame, 2'd0, 4'd0, 16'd0);
        for (int l = 0; l < `SCENE_NUM_LIGHTS; l++) fetch(l % 2, l);
        finish_test("light writes and unused codes", err0);

        err0 = errors;
        for (int p = 0; p < 5; p++) send_cmd(op_set_camera, 2'd0, 4'(p), random_bits(16));
        for (int p = 1; p < 4; p++) send_cmd(op_set_light, 2'd2, 4'(p), random_bits(16));
        fetch(0, 2);  // Still the old copy
        send_cmd(op_frame, 2'd0, 4'd0, 16'd0);
        fetch(0, 2);  // New fields next to stale ones
        fetch(1, 0);
        finish_test("double buffering", err0);

        err0 = errors;
        send_cmd(op_render, 2'd0, 4'd0, 16'd0);
        check_bit("frame_ready", frame_ready, model_ready);
        fetch(0, 2);
        fetch(1, 3);
        finish_test("render clears frame_ready", err0);

        err0 = errors;
        for (int n = 0; n < 24; n++) begin
            r_op   = 2'(random_bits(2));
            r_idx  = 2'(random_bits(2));
            r_prop = 4'(random_bits(4));
            send_cmd(scene_op_e'(r_op), r_idx, r_prop, random_bits(16));  // Next req right away
        end
        send_cmd(op_frame, 2'd0, 4'd0, 16'd0);
        check_bit("frame_ready", frame_ready, model_ready);
        for (int l = 0; l < `SCENE_NUM_LIGHTS; l++) fetch(l % 2, l);
        send_cmd(op_frame, 2'd0, 4'd0, 16'd0);  // Bring the other copy to the render side
        for (int l = 0; l < `SCENE_NUM_LIGHTS; l++) fetch(l % 2, l);
        finish_test("back-to-back commands", err0);

        if (exp_cam_q.size() != 0) begin
            errors++;
            $display("%0d fetch results were never compared", exp_cam_q.size());
        end
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
rtl/scene_types_pkg.sv
rtl/scene_cmd_pkg.sv
rtl/scene_cmd_intake.sv
rtl/scene_updater.sv
rtl/scene_bank.sv
rtl/render_fetch.sv
rtl/scene_memory_top.sv
sim/tb_clock_gen.sv
sim/scene_memory_tb.sv

// File: Bender.yml
package:
  name: scene_memory

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/scene_types_pkg.sv
      - rtl/scene_cmd_pkg.sv
      - rtl/scene_cmd_intake.sv
      - rtl/scene_updater.sv
      - rtl/scene_bank.sv
      - rtl/render_fetch.sv
      - rtl/scene_memory_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/tb_clock_gen.sv
      - sim/scene_memory_tb.sv
